/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module port_fifo_tb -Mdir obj_dir
	./obj_dir/Vport_fifo_tb | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/port_fifo_assertions.sv */
// Output handshake assertions, bound into the FIFO top level
`timescale 1ns/1ps
`default_nettype none

module port_fifo_assertions (
	input wire                       clk,
	input wire                       rst_n,
	input wire port_fifo_pkg::data_t out_data,
	input wire                       out_sof,
	input wire                       out_eof,
	input wire                       out_src_rdy,
	input wire                       out_dst_rdy
);

	// Stalled word keeps its payload and flags
	a_hold_word: assert property (@(posedge clk) disable iff (!rst_n)
		out_src_rdy && !out_dst_rdy |=> $stable(out_data) && $stable(out_sof) && $stable(out_eof))
		else $error("Output word changed while stalled");

	// Valid stays up until the word transfers
	a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
		out_src_rdy && !out_dst_rdy |=> out_src_rdy)
		else $error("out_src_rdy dropped before transfer");

	a_reset_idle: assert property (@(posedge clk) !rst_n |=> !out_src_rdy)
		else $error("out_src_rdy high right after reset");

endmodule

bind port_fifo port_fifo_assertions u_assert (
	.clk (clk), .rst_n (rst_n),
	.out_data (out_data), .out_sof (out_sof), .out_eof (out_eof),
	.out_src_rdy (out_src_rdy), .out_dst_rdy (out_dst_rdy)
);

`default_nettype wire

/* bench/port_fifo_tb.sv */
// Testbench for the packet port FIFO
// Random frames, stray words and cut frames checked against a frame-level model
`timescale 1ns/1ps
`default_nettype none

module port_fifo_tb;

	localparam int N_FRAMES   = 200;
	localparam int MAX_LEN    = 20;
	localparam int TIMEOUT_NS = N_FRAMES * 40 * 4;	// 40 cycles per frame at 4 ns

	logic                 clk;
	logic                 rst_n;
	port_fifo_pkg::data_t in_data;
	logic                 in_sof;
	logic                 in_eof;
	logic                 in_src_rdy;
	logic                 in_dst_rdy;
	port_fifo_pkg::data_t out_data;
	logic                 out_sof;
	logic                 out_eof;
	logic                 out_src_rdy;
	logic                 out_dst_rdy;

	integer               seed;
	logic [9:0]           exp_q [$];	// {sof, eof, byte} in output order
	port_fifo_pkg::data_t cur_q [$];	// Bytes of the frame being received
	logic [9:0]           want;
	logic                 in_frame;
	int                   errors, words_out, stalls, stall_left;
	int                   n_stray, n_cut, n_long;

	port_fifo UUT (
		.clk (clk), .rst_n (rst_n),
		.in_data (in_data), .in_sof (in_sof), .in_eof (in_eof),
		.in_src_rdy (in_src_rdy), .in_dst_rdy (in_dst_rdy),
		.out_data (out_data), .out_sof (out_sof), .out_eof (out_eof),
		.out_src_rdy (out_src_rdy), .out_dst_rdy (out_dst_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	function automatic int unsigned pick(input int unsigned n);
		return {$random(seed)} % n;
	endfunction

	// One clock step, sink readiness with occasional long stalls
	task automatic next_cycle();
		@(posedge clk);
		if (stall_left != 0)
			stall_left--;
		else if (pick(96) == 0)
			stall_left = 20 + pick(16);	// Long enough to fill the buffer
		out_dst_rdy <= (stall_left == 0) && (pick(4) != 0);
	endtask

	// Frame rules applied to every accepted input word
	function automatic void model_accept(input port_fifo_pkg::data_t d, input logic s,
		input logic e);
		int n;
		if (s) begin
			cur_q.delete();	// New sof discards any partial frame
			in_frame = 1'b1;
		end
		if (in_frame) begin
			cur_q.push_back(d);
			if (e) begin
				n = cur_q.size();
				in_frame = 1'b0;
				if (n < port_fifo_pkg::DEPTH) begin
					for (int i = 0; i < n; i++)
						exp_q.push_back({i == 0, i == n - 1, cur_q[i]});
				end else begin
					n_long++;	// Oversize, never released
				end
				cur_q.delete();
			end
		end
	endfunction

	task automatic send_word(input port_fifo_pkg::data_t d, input logic s, input logic e);
		logic acc;
		while (pick(4) == 0) begin	// Random idle before the word
			in_src_rdy <= 1'b0;
			next_cycle();
		end
		in_data    <= d;
		in_sof     <= s;
		in_eof     <= e;
		in_src_rdy <= 1'b1;
		acc = 1'b0;
		while (!acc) begin
			@(negedge clk);
			acc = in_dst_rdy;	// Transfer on the coming edge
			if (!acc)
				stalls++;
			next_cycle();
		end
		model_accept(d, s, e);
	endtask

	task automatic send_frame(input int len, input logic close);
		for (int i = 0; i < len; i++)
			send_word(port_fifo_pkg::data_t'(pick(256)), i == 0, close && (i == len - 1));
	endtask

	// Output checker, compares each transfer with the model
	always @(negedge clk) begin
		if (rst_n && out_src_rdy && out_dst_rdy) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERR %0t: output byte %h with no committed frame", $time, out_data);
			end else begin
				want = exp_q.pop_front();
				if ({out_sof, out_eof, out_data} !== want) begin
					errors++;
					$display("ERR %0t: got sof=%b eof=%b data=%h, expected sof=%b eof=%b data=%h",
						$time, out_sof, out_eof, out_data, want[9], want[8], want[7:0]);
				end
			end
			words_out++;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Run timed out after %0d ns, %0d bytes still expected", TIMEOUT_NS,
			exp_q.size());
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		seed = 32'h46c0ba86;
		{errors, words_out, stalls, stall_left, n_stray, n_cut, n_long} = '0;
		in_frame    = 1'b0;
		rst_n       = 1'b0;
		in_data     = '0;
		in_sof      = 1'b0;
		in_eof      = 1'b0;
		in_src_rdy  = 1'b0;
		out_dst_rdy = 1'b0;
		repeat (3) next_cycle();
		rst_n <= 1'b1;
		@(negedge clk);
		if (out_src_rdy !== 1'b0 || in_dst_rdy !== 1'b1) begin
			errors++;
			$display("ERR %0t: after reset out_src_rdy=%b in_dst_rdy=%b", $time, out_src_rdy,
				in_dst_rdy);
		end
		next_cycle();
		for (int f = 0; f < N_FRAMES; f++) begin
			repeat (pick(4)) begin	// Gap between frames
				in_src_rdy <= 1'b0;
				next_cycle();
			end
			case (pick(16))
				0: begin
					send_word(port_fifo_pkg::data_t'(pick(256)), 1'b0, pick(2) == 0);
					n_stray++;
				end
				1: begin
					send_frame(1 + pick(5), 1'b0);	// Cut short by the next sof
					n_cut++;
				end
				default: ;
			endcase
			send_frame(1 + pick(MAX_LEN), 1'b1);
		end
		in_src_rdy <= 1'b0;
		while (exp_q.size() != 0)
			next_cycle();
		repeat (20) next_cycle();	// Nothing extra may follow
		@(negedge clk);
		if (out_src_rdy) begin
			errors++;
			$display("ERR %0t: output still valid after all frames drained", $time);
		end
		if (stalls == 0) begin
			errors++;
			$display("Input was never back-pressured, so the full buffer was not exercised");
		end
		$display("Frames %0d, strays %0d, cut %0d, oversize %0d, bytes out %0d, errors %0d",
			N_FRAMES, n_stray, n_cut, n_long, words_out, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hdl/port_fifo_pkg.sv
hdl/frame_rx.sv
hdl/frame_buffer.sv
hdl/frame_tx.sv
hdl/port_fifo.sv
bench/port_fifo_assertions.sv
bench/port_fifo_tb.sv

/* hdl/frame_buffer.sv */
// Frame storage RAM with registered read port
// Write, committed and read pointers plus free-space count
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
	input  wire                   clk,
	input  wire                   rst_n,
	// Write side
	input  wire                   wr_en,
	input  port_fifo_pkg::entry_t wr_entry,
	input  wire                   commit,
	input  wire                   rollback,
	// Read side
	input  wire                   rd_en,
	output port_fifo_pkg::entry_t rd_entry,
	output logic                  full,
	output logic                  frame_avail
);

	localparam int AW = port_fifo_pkg::ADDR_W;

	port_fifo_pkg::entry_t mem [port_fifo_pkg::DEPTH];

	port_fifo_pkg::ptr_t wr_ptr;		// Next free word
	port_fifo_pkg::ptr_t commit_ptr;	// End of last whole frame
	port_fifo_pkg::ptr_t rd_ptr;		// Next word to read
	port_fifo_pkg::ptr_t wr_base;		// Write address after rollback
	port_fifo_pkg::ptr_t wr_ptr_nxt;
	port_fifo_pkg::ptr_t free_cnt;

	// Rollback restarts writing at the committed pointer in the same cycle
	assign wr_base    = rollback ? commit_ptr : wr_ptr;
	assign wr_ptr_nxt = wr_base + port_fifo_pkg::ptr_t'(wr_en);

	// Space counts against the read pointer, uncommitted words included
	assign free_cnt = port_fifo_pkg::ptr_t'(port_fifo_pkg::DEPTH) - (wr_ptr - rd_ptr);
	assign full     = (free_cnt == '0);

	// Only committed words are visible to the reader
	assign frame_avail = (commit_ptr != rd_ptr);

	// RAM write
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_base[AW-1:0]] <= wr_entry;
	end

	// Registered read, data valid the cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_entry <= mem[rd_ptr[AW-1:0]];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			commit_ptr <= '0;
			rd_ptr     <= '0;
		end else begin
			wr_ptr <= wr_ptr_nxt;
			if (commit)
				commit_ptr <= wr_ptr_nxt;	// Includes the eof word
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/frame_rx.sv */
// Input-side framing checker
// Writes frame words to the buffer, commits on eof, rolls back bad frames
`timescale 1ns/1ps
`default_nettype none

module frame_rx (
	input  wire                   clk,
	input  wire                   rst_n,
	// Input stream
	input  port_fifo_pkg::data_t  in_data,
	input  wire                   in_sof,
	input  wire                   in_eof,
	input  wire                   in_src_rdy,
	output logic                  in_dst_rdy,
	// Buffer side
	output logic                  wr_en,
	output port_fifo_pkg::entry_t wr_entry,
	output logic                  commit,
	output logic                  rollback,
	input  wire                   full
);

	port_fifo_pkg::rx_state_t state, state_nxt;
	port_fifo_pkg::len_t      len, len_nxt;
	logic                     needs_slot;	// Word may land in the buffer
	logic                     xfer;

	// Only words that could be written need a free slot
	assign needs_slot = in_sof || (state == port_fifo_pkg::RX_FRAME);
	assign in_dst_rdy = !full || !needs_slot;
	assign xfer       = in_src_rdy && in_dst_rdy;

	assign wr_entry = {in_eof, in_data};	// eof flag rides on top

	always_comb begin
		state_nxt = state;
		len_nxt   = len;
		wr_en     = 1'b0;
		commit    = 1'b0;
		rollback  = 1'b0;
		if (xfer) begin
			if (in_sof) begin
				// New frame, throw away any partial one
				rollback = (state == port_fifo_pkg::RX_FRAME);
				wr_en    = 1'b1;
				len_nxt  = port_fifo_pkg::len_t'(1);
				if (in_eof) begin
					commit    = 1'b1;	// Single-word frame
					state_nxt = port_fifo_pkg::RX_IDLE;
				end else begin
					state_nxt = port_fifo_pkg::RX_FRAME;
				end
			end else begin
				case (state)
					port_fifo_pkg::RX_FRAME: begin
						if (in_eof) begin
							wr_en     = 1'b1;
							commit    = 1'b1;
							state_nxt = port_fifo_pkg::RX_IDLE;
						end else if (len == port_fifo_pkg::len_t'(port_fifo_pkg::DEPTH - 2)) begin
							// Next length would hit DEPTH-1 with no eof
							rollback  = 1'b1;
							state_nxt = port_fifo_pkg::RX_DROP;
						end else begin
							wr_en   = 1'b1;
							len_nxt = len + 1'b1;
						end
					end
					port_fifo_pkg::RX_DROP: begin
						if (in_eof)
							state_nxt = port_fifo_pkg::RX_IDLE;	// Oversize frame gone
					end
					default: ;	// Stray word outside a frame
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= port_fifo_pkg::RX_IDLE;
			len   <= '0;
		end else begin
			state <= state_nxt;
			len   <= len_nxt;
		end
	end

endmodule

`default_nettype wire

/* hdl/frame_tx.sv */
// Output-side stage, two-entry register queue fed by buffer reads
// Regenerates sof and eof and holds its word under back-pressure
`timescale 1ns/1ps
`default_nettype none

module frame_tx (
	input  wire                   clk,
	input  wire                   rst_n,
	// Buffer side
	input  wire                   frame_avail,
	output logic                  rd_en,
	input  port_fifo_pkg::entry_t rd_entry,
	// Output stream
	output port_fifo_pkg::data_t  out_data,
	output logic                  out_sof,
	output logic                  out_eof,
	output logic                  out_src_rdy,
	input  wire                   out_dst_rdy
);

	localparam int DW = port_fifo_pkg::DATA_W;

	port_fifo_pkg::entry_t slot_q [2];	// Slot 0 is on the output
	logic                  slot_sof [2];
	logic [1:0]            cnt;		// Occupied slots
	logic                  pend;		// Read in flight, rd_entry valid now
	logic                  at_start;	// Next pushed word opens a frame
	logic                  push;
	logic                  pop;
	logic                  push_idx;
	logic [1:0]            room_used;

	assign push = pend;
	assign pop  = out_src_rdy && out_dst_rdy;

	// Slots claimed once this cycle's pop leaves
	assign room_used = cnt + {1'b0, pend} - {1'b0, pop};
	assign rd_en     = frame_avail && (room_used < 2'd2);

	// Push lands behind whatever survives the pop
	assign push_idx = pop ? (cnt == 2'd2) : (cnt == 2'd1);

	assign out_src_rdy = (cnt != 2'd0);
	assign out_data    = slot_q[0][DW-1:0];
	assign out_sof     = out_src_rdy && slot_sof[0];
	assign out_eof     = out_src_rdy && slot_q[0][DW];

	// Payload slots, shift toward the output on pop
	always_ff @(posedge clk) begin
		if (pop) begin
			slot_q[0]   <= slot_q[1];
			slot_sof[0] <= slot_sof[1];
		end
		if (push) begin
			slot_q[push_idx]   <= rd_entry;	// Overrides the shift if same slot
			slot_sof[push_idx] <= at_start;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt      <= 2'd0;
			pend     <= 1'b0;
			at_start <= 1'b1;	// First word after reset opens a frame
		end else begin
			cnt  <= cnt + {1'b0, push} - {1'b0, pop};
			pend <= rd_en;
			if (push)
				at_start <= rd_entry[DW];	// Word after eof starts the next frame
		end
	end

endmodule

`default_nettype wire

/* hdl/port_fifo.sv */
// Store-and-forward packet port FIFO top level
// Receiver, frame buffer and transmitter
`timescale 1ns/1ps
`default_nettype none

module port_fifo (
	input  wire                  clk,
	input  wire                  rst_n,
	// Input stream
	input  port_fifo_pkg::data_t in_data,
	input  wire                  in_sof,
	input  wire                  in_eof,
	input  wire                  in_src_rdy,
	output logic                 in_dst_rdy,
	// Output stream
	output port_fifo_pkg::data_t out_data,
	output logic                 out_sof,
	output logic                 out_eof,
	output logic                 out_src_rdy,
	input  wire                  out_dst_rdy
);

	// Receiver to buffer
	logic                  wr_en;
	port_fifo_pkg::entry_t wr_entry;
	logic                  commit;
	logic                  rollback;
	logic                  full;
	// Buffer to transmitter
	logic                  rd_en;
	port_fifo_pkg::entry_t rd_entry;
	logic                  frame_avail;

	frame_rx u_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_data    (in_data),
		.in_sof     (in_sof),
		.in_eof     (in_eof),
		.in_src_rdy (in_src_rdy),
		.in_dst_rdy (in_dst_rdy),
		.wr_en      (wr_en),
		.wr_entry   (wr_entry),
		.commit     (commit),
		.rollback   (rollback),
		.full       (full)
	);

	frame_buffer u_buf (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.wr_entry    (wr_entry),
		.commit      (commit),
		.rollback    (rollback),
		.rd_en       (rd_en),
		.rd_entry    (rd_entry),
		.full        (full),
		.frame_avail (frame_avail)
	);

	frame_tx u_tx (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_avail (frame_avail),
		.rd_en       (rd_en),
		.rd_entry    (rd_entry),
		.out_data    (out_data),
		.out_sof     (out_sof),
		.out_eof     (out_eof),
		.out_src_rdy (out_src_rdy),
		.out_dst_rdy (out_dst_rdy)
	);

endmodule

`default_nettype wire

/* hdl/port_fifo_pkg.sv */
// Shared depth, widths and vector types for the packet port FIFO
// Also holds the receiver state encoding
`default_nettype none

package port_fifo_pkg;

	// Stream byte width
	localparam int DATA_W = 8;

	// Buffer words, a frame must stay below this
	localparam int DEPTH = 16;

	// RAM address bits
	localparam int ADDR_W = $clog2(DEPTH);

	// Address plus wrap bit
	localparam int PTR_W = ADDR_W + 1;

	// One stream byte
	typedef logic [DATA_W-1:0] data_t;

	// Wrapping buffer address
	typedef logic [PTR_W-1:0] ptr_t;

	// Stored word, eof flag on top
	typedef logic [DATA_W:0] entry_t;

	// Words of the frame in progress
	typedef logic [PTR_W-1:0] len_t;

	// Input framing checker states
	typedef enum logic [1:0] {
		RX_IDLE,	// Waiting for sof
		RX_FRAME,	// Frame in progress, words go to the buffer
		RX_DROP		// Oversize frame, swallow up to eof
	} rx_state_t;

endpackage

`default_nettype wire
